/* rtl/xt_periph_pkg.sv */
/*
 * XT peripheral block shared definitions
 * Bus widths, legacy port map, ROM and EMS window prefixes, reset values
 * and the decoded view of a byte written to an EMS page register.
 */
package xt_periph_pkg;

    // Bus widths
    localparam int ADDR_W     = 20;
    localparam int DATA_W     = 8;
    localparam int IO_ADDR_W  = 16;
    localparam int EMS_PAGE_W = 7;

    // Four page registers, one per 16 KB slot of the frame
    localparam int EMS_BANKS  = 4;

    // I/O ports
    // EMS registers sit at 260h..263h, low two bits pick the bank
    localparam logic [IO_ADDR_W-1:0] EMS_PORT_BASE = 16'h0260;
    localparam logic [IO_ADDR_W-1:0] LPT_DATA_PORT = 16'h0378;

    // DMA, PIC, PIT, PPI and DMA page, each a 32-port block below 100h
    localparam int LEGACY_CS_N = 5;

    // Memory windows by top address bits
    // BIOS at F0000..FFFFF
    localparam logic [3:0] BIOS_PREFIX  = 4'hF;
    // XT-IDE option ROM at EC000..EFFFF
    localparam logic [5:0] XTIDE_PREFIX = 6'b111011;

    // Selectable EMS frames at A000h, C000h and D000h
    localparam logic [3:0] EMS_FRAME_A = 4'hA;
    localparam logic [3:0] EMS_FRAME_C = 4'hC;
    localparam logic [3:0] EMS_FRAME_D = 4'hD;

    // EMS register codes
    // Writing FFh unmaps the bank
    localparam logic [DATA_W-1:0] EMS_DISABLE_CODE  = 8'hFF;
    localparam logic [DATA_W-1:0] EMS_UNMAPPED_READ = 8'hFF;

    // Parallel port data after reset
    localparam logic [DATA_W-1:0] LPT_RESET_VALUE = 8'hFF;

    // Page command view of a written byte
    typedef struct packed {
        logic                  reject;
        logic [EMS_PAGE_W-1:0] page;
    } ems_page_cmd_t;

    // One EMS write byte, seen whole or as a page command
    typedef union packed {
        logic [DATA_W-1:0] raw;
        ems_page_cmd_t     page_cmd;
    } ems_write_u;

endpackage

/* rtl/io_decoder.sv */
/*
 * XT address decoder
 * Turns I/O and memory cycles into the legacy chip selects, the ROM window
 * selects and the EMS and parallel port matches.
 */
`timescale 1ns/1ps

module io_decoder
    import xt_periph_pkg::*;
(
    input  logic [ADDR_W-1:0]      address_i,
    input  logic                   address_enable_n_i,
    input  logic                   io_read_n_i,
    input  logic                   io_write_n_i,
    input  logic                   ems_enabled_i,
    output logic [LEGACY_CS_N-1:0] legacy_cs_n_o,
    output logic                   bios_select_n_o,
    output logic                   xtide_select_n_o,
    output logic                   ems_port_sel_o,
    output logic                   lpt_sel_o,
    output logic                   mem_cycle_o
);

    logic [IO_ADDR_W-1:0] io_address;
    logic                 io_cycle;
    logic                 legacy_range;

    // I/O space is the low 16 address bits
    assign io_address = address_i[IO_ADDR_W-1:0];

    // Either strobe low marks an I/O cycle
    assign io_cycle = ~io_read_n_i | ~io_write_n_i;

    // Memory cycle when the CPU owns the bus and no I/O strobe is active
    assign mem_cycle_o = ~address_enable_n_i & io_read_n_i & io_write_n_i;

    // Motherboard chips live below 100h
    assign legacy_range = io_cycle & ~address_enable_n_i
                        & (io_address[IO_ADDR_W-1:8] == '0);

    // One select per 32-port block, bits 7..5 pick the block
    always_comb begin
        for (int i = 0; i < LEGACY_CS_N; i++) begin
            legacy_cs_n_o[i] = ~(legacy_range && (io_address[7:5] == 3'(i)));
        end
    end

    // ROM windows
    assign bios_select_n_o  = ~(mem_cycle_o && (address_i[19:16] == BIOS_PREFIX));
    assign xtide_select_n_o = ~(mem_cycle_o && (address_i[19:14] == XTIDE_PREFIX));

    // EMS register block 260h..263h, only when EMS is switched on
    assign ems_port_sel_o = io_cycle & ~address_enable_n_i & ems_enabled_i
                          & (io_address[IO_ADDR_W-1:2] == EMS_PORT_BASE[IO_ADDR_W-1:2]);

    // Parallel port data register, exact match
    assign lpt_sel_o = io_cycle & (io_address == LPT_DATA_PORT);

endmodule

/* rtl/ems_mapper.sv */
/*
 * EMS page mapper
 * Four page registers written through I/O ports, translation of memory
 * cycles in the chosen 64 KB frame into bank and page, register readback.
 */
`timescale 1ns/1ps

module ems_mapper
    import xt_periph_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic [ADDR_W-1:0]     address_i,
    input  logic [DATA_W-1:0]     data_i,
    input  logic                  io_write_n_i,
    input  logic                  ems_port_sel_i,
    input  logic                  mem_cycle_i,
    input  logic [1:0]            ems_frame_sel_i,
    output logic [DATA_W-1:0]     ems_read_data_o,
    output logic                  ems_hit_o,
    output logic [1:0]            ems_bank_o,
    output logic [EMS_PAGE_W-1:0] ems_page_o
);

    logic [EMS_PAGE_W-1:0] page_q   [EMS_BANKS];
    logic                  enable_q [EMS_BANKS];

    ems_write_u            write_byte;
    logic [1:0]            port_bank;
    logic [1:0]            frame_bank;
    logic [3:0]            frame_prefix;
    logic                  in_frame;

    assign write_byte = data_i;

    // Register selected by port address
    assign port_bank = address_i[1:0];

    // Page register updates
    // FFh unmaps, 00h..7Fh maps that page, 80h..FEh are ignored
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < EMS_BANKS; i++) begin
                page_q[i]   <= '0;
                enable_q[i] <= 1'b0;
            end
        end else if (ems_port_sel_i && !io_write_n_i) begin
            if (write_byte.raw == EMS_DISABLE_CODE) begin
                enable_q[port_bank] <= 1'b0;
                page_q[port_bank]   <= '1;
            end else if (!write_byte.page_cmd.reject) begin
                enable_q[port_bank] <= 1'b1;
                page_q[port_bank]   <= write_byte.page_cmd.page;
            end
        end
    end

    // Readback, unmapped banks float high like an empty bus
    always_comb begin
        if (enable_q[port_bank]) begin
            ems_read_data_o = {1'b0, page_q[port_bank]};
        end else begin
            ems_read_data_o = EMS_UNMAPPED_READ;
        end
    end

    // Frame base from the configuration switch
    always_comb begin
        case (ems_frame_sel_i)
            2'd0:    frame_prefix = EMS_FRAME_A;
            2'd1:    frame_prefix = EMS_FRAME_C;
            default: frame_prefix = EMS_FRAME_D;
        endcase
    end

    // Each 16 KB slot of the frame maps to one bank
    assign frame_bank = address_i[15:14];
    assign in_frame   = mem_cycle_i && (address_i[19:16] == frame_prefix);

    // Translation
    always_comb begin
        ems_hit_o  = 1'b0;
        ems_bank_o = 2'd0;
        ems_page_o = '0;
        if (in_frame && enable_q[frame_bank]) begin
            ems_hit_o  = 1'b1;
            ems_bank_o = frame_bank;
            ems_page_o = page_q[frame_bank];
        end
    end

endmodule

/* rtl/port_readback.sv */
/*
 * Parallel port latch and chipset read mux
 * Holds the byte written to the LPT data port and drives the chipset
 * read bus during I/O reads, EMS registers first, then the LPT latch.
 */
`timescale 1ns/1ps

module port_readback
    import xt_periph_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic [DATA_W-1:0] data_i,
    input  logic              io_read_n_i,
    input  logic              io_write_n_i,
    input  logic              ems_port_sel_i,
    input  logic              lpt_sel_i,
    input  logic [DATA_W-1:0] ems_read_data_i,
    output logic [DATA_W-1:0] data_bus_out_o,
    output logic              data_bus_out_from_chipset_o
);

    logic [DATA_W-1:0] lpt_data_q;
    logic              io_read;

    assign io_read = ~io_read_n_i;

    // LPT data latch
    // Rewritten on every edge of a held write strobe
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_data_q <= LPT_RESET_VALUE;
        end else if (lpt_sel_i && !io_write_n_i) begin
            lpt_data_q <= data_i;
        end
    end

    // Read data priority
    always_comb begin
        if (io_read && ems_port_sel_i) begin
            data_bus_out_from_chipset_o = 1'b1;
            data_bus_out_o              = ems_read_data_i;
        end else if (io_read && lpt_sel_i) begin
            data_bus_out_from_chipset_o = 1'b1;
            data_bus_out_o              = lpt_data_q;
        end else begin
            // Nobody drives, keep the bus quiet
            data_bus_out_from_chipset_o = 1'b0;
            data_bus_out_o              = '0;
        end
    end

endmodule

/* rtl/xt_peripherals.sv */
/*
 * XT peripheral block, decode and chipset registers
 * Connects the address decoder, the EMS mapper and the read data mux.
 */
`timescale 1ns/1ps

module xt_peripherals
    import xt_periph_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    // Bus
    input  logic [ADDR_W-1:0]      address_i,
    input  logic [DATA_W-1:0]      data_i,
    input  logic                   address_enable_n_i,
    input  logic                   io_read_n_i,
    input  logic                   io_write_n_i,
    // EMS configuration
    input  logic                   ems_enabled_i,
    input  logic [1:0]             ems_frame_sel_i,
    // Selects
    output logic [LEGACY_CS_N-1:0] legacy_cs_n_o,
    output logic                   bios_select_n_o,
    output logic                   xtide_select_n_o,
    // EMS translation
    output logic                   ems_hit_o,
    output logic [1:0]             ems_bank_o,
    output logic [EMS_PAGE_W-1:0]  ems_page_o,
    // Read data
    output logic [DATA_W-1:0]      data_bus_out_o,
    output logic                   data_bus_out_from_chipset_o
);

    logic              ems_port_sel;
    logic              lpt_sel;
    logic              mem_cycle;
    logic [DATA_W-1:0] ems_read_data;

    io_decoder u_io_decoder (
        .address_i          (address_i),
        .address_enable_n_i (address_enable_n_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .ems_enabled_i      (ems_enabled_i),
        .legacy_cs_n_o      (legacy_cs_n_o),
        .bios_select_n_o    (bios_select_n_o),
        .xtide_select_n_o   (xtide_select_n_o),
        .ems_port_sel_o     (ems_port_sel),
        .lpt_sel_o          (lpt_sel),
        .mem_cycle_o        (mem_cycle)
    );

    ems_mapper u_ems_mapper (
        .clock           (clock),
        .reset           (reset),
        .address_i       (address_i),
        .data_i          (data_i),
        .io_write_n_i    (io_write_n_i),
        .ems_port_sel_i  (ems_port_sel),
        .mem_cycle_i     (mem_cycle),
        .ems_frame_sel_i (ems_frame_sel_i),
        .ems_read_data_o (ems_read_data),
        .ems_hit_o       (ems_hit_o),
        .ems_bank_o      (ems_bank_o),
        .ems_page_o      (ems_page_o)
    );

    port_readback u_port_readback (
        .clock                       (clock),
        .reset                       (reset),
        .data_i                      (data_i),
        .io_read_n_i                 (io_read_n_i),
        .io_write_n_i                (io_write_n_i),
        .ems_port_sel_i              (ems_port_sel),
        .lpt_sel_i                   (lpt_sel),
        .ems_read_data_i             (ems_read_data),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

/* sim/tb_xt_peripherals_sva.sv */
/*
 * Bound assertions for the XT peripheral block
 * Idle chip selects, EMS hits outside memory cycles and the quiet read bus.
 */
`timescale 1ns/1ps

module tb_xt_peripherals_sva
    import xt_periph_pkg::*;
(
    input logic                   clock,
    input logic                   reset,
    input logic                   address_enable_n_i,
    input logic                   io_read_n_i,
    input logic                   io_write_n_i,
    input logic [LEGACY_CS_N-1:0] legacy_cs_n_o,
    input logic                   ems_hit_o,
    input logic [DATA_W-1:0]      data_bus_out_o,
    input logic                   data_bus_out_from_chipset_o
);

    // Chip selects need the CPU on the bus
    a_cs_idle: assert property (@(posedge clock) disable iff (reset)
        address_enable_n_i |-> (&legacy_cs_n_o))
        else $error("legacy chip select low while address enable is high");

    // Translation only happens in memory cycles
    a_hit_not_io: assert property (@(posedge clock) disable iff (reset)
        (!io_read_n_i || !io_write_n_i) |-> !ems_hit_o)
        else $error("EMS hit during an I/O cycle");

    a_quiet_bus: assert property (@(posedge clock) disable iff (reset)
        !data_bus_out_from_chipset_o |-> (data_bus_out_o == '0))
        else $error("read data not zero while the chipset does not drive");

endmodule

bind xt_peripherals tb_xt_peripherals_sva sva0 (
    .clock                       (clock),
    .reset                       (reset),
    .address_enable_n_i          (address_enable_n_i),
    .io_read_n_i                 (io_read_n_i),
    .io_write_n_i                (io_write_n_i),
    .legacy_cs_n_o               (legacy_cs_n_o),
    .ems_hit_o                   (ems_hit_o),
    .data_bus_out_o              (data_bus_out_o),
    .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
);

/* sim/tb_xt_peripherals.sv */
/*
 * Testbench for the XT peripheral block
 * Runs I/O and memory cycles through the top level and checks every output
 * against a reference model of the decode and register rules.
 */
`timescale 1ns/1ps

module tb_xt_peripherals
    import xt_periph_pkg::*;
();

    localparam int WAIT_LIMIT = 20;

    logic                   clock;
    logic                   reset;
    logic [ADDR_W-1:0]      address;
    logic [DATA_W-1:0]      data;
    logic                   address_enable_n;
    logic                   io_read_n;
    logic                   io_write_n;
    logic                   ems_enabled;
    logic [1:0]             ems_frame_sel;

    logic [LEGACY_CS_N-1:0] legacy_cs_n;
    logic                   bios_select_n;
    logic                   xtide_select_n;
    logic                   ems_hit;
    logic [1:0]             ems_bank;
    logic [EMS_PAGE_W-1:0]  ems_page;
    logic [DATA_W-1:0]      data_bus_out;
    logic                   data_bus_out_from_chipset;

    // Reference model state
    logic [6:0]             model_page [4];
    logic                   model_en   [4];
    logic [7:0]             model_lpt;

    // Outputs seen by the compare process at the last rising edge
    logic [4:0]             seen_cs;
    logic                   seen_bios;
    logic                   seen_xtide;
    logic                   seen_hit;
    logic [7:0]             seen_data;
    logic                   seen_chipset;

    logic [25:0]            expected_now;
    string                  tag;
    logic                   checking;
    logic                   timed_out;
    int                     sample_count;
    int                     check_count;
    int                     error_count;
    int                     errors_before;
    int                     test_count;
    logic [31:0]            rng_state;

    xt_peripherals dut0 (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (data),
        .address_enable_n_i          (address_enable_n),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .ems_enabled_i               (ems_enabled),
        .ems_frame_sel_i             (ems_frame_sel),
        .legacy_cs_n_o               (legacy_cs_n),
        .bios_select_n_o             (bios_select_n),
        .xtide_select_n_o            (xtide_select_n),
        .ems_hit_o                   (ems_hit),
        .ems_bank_o                  (ems_bank),
        .ems_page_o                  (ems_page),
        .data_bus_out_o              (data_bus_out),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset)
    );

    always #5 clock = ~clock;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Frame switch 0 is A000h, 1 is C000h, anything else D000h
    function automatic logic [3:0] frame_base(input logic [1:0] sel);
        case (sel)
            2'd0:    return 4'hA;
            2'd1:    return 4'hC;
            default: return 4'hD;
        endcase
    endfunction

    // Expected outputs packed as cs_n, bios_n, xtide_n, hit, bank, page, data, drive
    function automatic logic [25:0] expected_outputs(
        input logic [19:0] addr,
        input logic        aen_n,
        input logic        ior_n,
        input logic        iow_n,
        input logic        ems_en,
        input logic [1:0]  frame_sel
    );
        logic [4:0] cs_n;
        logic       io_cyc;
        logic       mem_cyc;
        logic       ems_port;
        logic       lpt_port;
        logic [1:0] slot;
        logic       hit;
        logic [7:0] dout;
        logic       drive;

        io_cyc  = !ior_n || !iow_n;
        mem_cyc = !aen_n && ior_n && iow_n;
        cs_n    = 5'b11111;
        if (io_cyc && !aen_n && addr[15:8] == 8'h00 && addr[7:5] < 3'd5) begin
            cs_n[addr[7:5]] = 1'b0;
        end
        ems_port = io_cyc && !aen_n && ems_en
                   && addr[15:0] >= 16'h0260 && addr[15:0] <= 16'h0263;
        lpt_port = io_cyc && addr[15:0] == 16'h0378;
        slot     = addr[15:14];
        hit      = mem_cyc && addr[19:16] == frame_base(frame_sel) && model_en[slot];
        drive    = !ior_n && (ems_port || lpt_port);
        if (!drive) begin
            dout = 8'h00;
        end else if (ems_port) begin
            dout = model_en[addr[1:0]] ? {1'b0, model_page[addr[1:0]]} : 8'hFF;
        end else begin
            dout = model_lpt;
        end
        return {cs_n, !(mem_cyc && addr[19:16] == 4'hF),
                !(mem_cyc && addr[19:14] == 6'b111011), hit,
                hit ? slot : 2'd0, hit ? model_page[slot] : 7'd0, dout, drive};
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, actual,
                     expected);
        end
    endtask

    // Compare process, outputs are stable since the falling edge
    always @(posedge clock) begin
        if (checking) begin
            expected_now = expected_outputs(address, address_enable_n, io_read_n,
                                            io_write_n, ems_enabled, ems_frame_sel);
            tag = $sformatf(" at address %05h", address);
            check_value({"legacy_cs_n", tag}, legacy_cs_n, expected_now[25:21]);
            check_value({"bios_select_n", tag}, bios_select_n, expected_now[20]);
            check_value({"xtide_select_n", tag}, xtide_select_n, expected_now[19]);
            check_value({"ems_hit", tag}, ems_hit, expected_now[18]);
            check_value({"ems_bank", tag}, ems_bank, expected_now[17:16]);
            check_value({"ems_page", tag}, ems_page, expected_now[15:9]);
            check_value({"data_bus_out", tag}, data_bus_out, expected_now[8:1]);
            check_value({"bus drive flag", tag}, data_bus_out_from_chipset, expected_now[0]);
            seen_cs      = legacy_cs_n;
            seen_bios    = bios_select_n;
            seen_xtide   = xtide_select_n;
            seen_hit     = ems_hit;
            seen_data    = data_bus_out;
            seen_chipset = data_bus_out_from_chipset;
            sample_count++;
        end
    end

    task automatic wait_samples(input int count, input string what);
        int target;
        int cycles;
        target = sample_count + count;
        cycles = 0;
        while (!timed_out && sample_count < target && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!timed_out && sample_count < target) begin
            timed_out = 1'b1;
            $display("Timeout: the compare process did not sample the %s within %0d cycles",
                     what, WAIT_LIMIT);
        end
    endtask

    // Called on a falling edge, holds the cycle for two clocks
    task automatic drive_cycle(input logic [19:0] addr, input logic [7:0] value,
                               input logic ior_n, input logic iow_n, input string what);
        if (!timed_out) begin
            address          = addr;
            data             = value;
            address_enable_n = 1'b0;
            io_read_n        = ior_n;
            io_write_n       = iow_n;
            wait_samples(2, what);
        end
    endtask

    task automatic model_write(input logic [19:0] addr, input logic [7:0] value);
        logic [1:0] bank;
        bank = addr[1:0];
        if (ems_enabled && addr[15:0] >= 16'h0260 && addr[15:0] <= 16'h0263) begin
            if (value == 8'hFF) begin
                model_en[bank]   = 1'b0;
                model_page[bank] = 7'h7F;
            end else if (value < 8'h80) begin
                model_en[bank]   = 1'b1;
                model_page[bank] = value[6:0];
            end
        end
        if (addr[15:0] == 16'h0378) begin
            model_lpt = value;
        end
    endtask

    task automatic io_write(input logic [19:0] addr, input logic [7:0] value);
        drive_cycle(addr, value, 1'b1, 1'b0, "I/O write");
        model_write(addr, value);
    endtask

    task automatic io_read(input logic [19:0] addr);
        drive_cycle(addr, 8'h00, 1'b0, 1'b1, "I/O read");
    endtask

    task automatic mem_probe(input logic [19:0] addr);
        drive_cycle(addr, 8'h00, 1'b1, 1'b1, "memory probe");
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d mismatches", test_count, name,
                     error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    initial begin
        logic [7:0] value;
        logic [7:0] ems_readback [4];
        logic [4:0] cs_expected;
        logic [1:0] off_bank;
        int         bank;

        clock            = 1'b0;
        reset            = 1'b1;
        address          = '0;
        data             = '0;
        address_enable_n = 1'b1;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        ems_enabled      = 1'b0;
        ems_frame_sel    = 2'd0;
        checking         = 1'b0;
        timed_out        = 1'b0;
        sample_count     = 0;
        check_count      = 0;
        error_count      = 0;
        errors_before    = 0;
        test_count       = 0;
        rng_state        = 32'h2e82_2bd0;
        model_lpt        = 8'hFF;
        for (int b = 0; b < 4; b++) begin
            model_en[b]     = 1'b0;
            model_page[b]   = 7'h00;
            ems_readback[b] = 8'hFF;
        end

        repeat (5) @(posedge clock);
        @(negedge clock);
        reset    = 1'b0;
        checking = 1'b1;

        // Reset state
        ems_enabled = 1'b1;
        for (int b = 0; b < 4; b++) begin
            io_read(20'h00260 + 20'(b));
            check_value("EMS readback after reset", seen_data, 8'hFF);
        end
        io_read(20'h00378);
        check_value("LPT readback after reset", seen_data, 8'hFF);
        for (int f = 0; f < 3; f++) begin
            ems_frame_sel = 2'(f);
            for (int b = 0; b < 4; b++) begin
                mem_probe({frame_base(2'(f)), 2'(b), 14'(next_random())});
                check_value("EMS hit after reset", seen_hit, 1'b0);
            end
        end
        end_test("reset state");

        // Legacy chip selects and ROM windows
        for (int blk = 0; blk < 5; blk++) begin
            io_read(20'(blk * 32) + 20'(next_random() % 32));
            cs_expected = ~(5'b00001 << blk);
            check_value("legacy select", seen_cs, cs_expected);
        end
        for (int i = 0; i < 6; i++) begin
            io_read(20'h00100 + 20'(next_random() % 32'h300));
            check_value("legacy select above 100h", seen_cs, 5'h1F);
        end
        for (int i = 0; i < 4; i++) begin
            mem_probe(20'hF0000 + 20'(next_random() % 32'h10000));
            check_value("BIOS select", seen_bios, 1'b0);
            mem_probe(20'hEC000 + 20'(next_random() % 32'h4000));
            check_value("XT-IDE select", seen_xtide, 1'b0);
        end
        end_test("legacy decode");

        // EMS register programming, a third of the writes unmap
        for (int i = 0; i < 24; i++) begin
            bank  = int'(next_random() % 4);
            value = 8'(next_random());
            if (i % 3 == 0) begin
                value = 8'hFF;
            end else if (i % 3 == 1) begin
                value = value & 8'h7F;
            end
            io_write(20'h00260 + 20'(bank), value);
            if (value == 8'hFF || value < 8'h80) begin
                ems_readback[bank] = value;
            end
            io_read(20'h00260 + 20'(bank));
            check_value("EMS readback", seen_data, ems_readback[bank]);
        end
        ems_enabled = 1'b0;
        io_read(20'h00260 + 20'(next_random() % 4));
        check_value("bus drive with EMS off", seen_chipset, 1'b0);
        ems_enabled = 1'b1;
        end_test("EMS programming");

        // EMS translation with one bank unmapped
        for (int b = 0; b < 4; b++) begin
            io_write(20'h00260 + 20'(b), 8'(next_random()) & 8'h7F);
        end
        off_bank = 2'(next_random());
        io_write(20'h00260 + 20'(off_bank), 8'hFF);
        for (int f = 0; f < 4; f++) begin
            ems_frame_sel = 2'(f);
            for (int b = 0; b < 4; b++) begin
                mem_probe({frame_base(2'(f)), 2'(b), 14'(next_random())});
                check_value("EMS hit in frame", seen_hit, 2'(b) != off_bank);
            end
            mem_probe({4'hB, 2'(next_random()), 14'(next_random())});
            check_value("EMS hit outside frame", seen_hit, 1'b0);
        end
        end_test("EMS translation");

        // Parallel port latch
        value = 8'(next_random());
        io_write(20'h00378, value);
        io_read(20'h00378);
        check_value("LPT readback", seen_data, value);
        io_write(20'h00379, ~value);
        io_read(20'h00378);
        check_value("LPT after write to 379h", seen_data, value);
        io_read(20'h00379);
        check_value("bus drive at 379h", seen_chipset, 1'b0);
        end_test("LPT latch");

        address_enable_n = 1'b1;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        wait_samples(1, "idle cycle");

        $display("%0d tests, %0d checks, %0d mismatches%s", test_count, check_count,
                 error_count, timed_out ? ", stopped by a timeout" : "");
        if (timed_out || error_count != 0) begin
            $display("SOME TESTS FAILED");
        end else begin
            $display("ALL TESTS PASSED");
        end
        $finish;
    end

endmodule

/* filelist.f */
rtl/xt_periph_pkg.sv
rtl/io_decoder.sv
rtl/ems_mapper.sv
rtl/port_readback.sv
rtl/xt_peripherals.sv
sim/tb_xt_peripherals_sva.sv
sim/tb_xt_peripherals.sv

/* Bender.yml */
package:
  name: xt_peripherals

sources:
  # Shared package first, then the blocks and the top level
  - rtl/xt_periph_pkg.sv
  - rtl/io_decoder.sv
  - rtl/ems_mapper.sv
  - rtl/port_readback.sv
  - rtl/xt_peripherals.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/tb_xt_peripherals_sva.sv
      - sim/tb_xt_peripherals.sv
